/* rs_top.f */
+incdir+rtl
rtl/rs_pkg.sv
rtl/rs_entry_if.sv
rtl/rs_entry_array.sv
rtl/rs_dispatch_alloc.sv
rtl/rs_issue_select.sv
rtl/rs_top.sv
tests/tb_rs_top.sv

/* Makefile */
# Verilator build for the reservation station testbench

VERILATOR ?= verilator
TOP       ?= tb_rs_top
RTL_TOP   ?= rs_top
FILELIST  ?= rs_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ** PASS **
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/tb_rs_top.sv */
//--------------------------------------------------------------------
// Testbench for the reservation station top level
// Tag-indexed reference model, concurrent checks and directed/random stimulus
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rs_params.svh"

module tb_rs_top;

    localparam int NTAG          = 1 << `TAG_WIDTH;
    localparam int MAX_CYCLES    = 3000;
    localparam int STRESS_CYCLES = 1200;

    logic                                   clk_i;
    logic                                   rst_i;
    logic                                   flush_i;
    rs_pkg::rs_cnt_t                        dp_num_i;
    rs_pkg::rs_inst_t [`DP_NUM-1:0]         dp_inst_i;
    rs_pkg::rs_cnt_t                        avail_num_o;
    logic [`CDB_NUM-1:0]                    cdb_valid_i;
    rs_pkg::tag_t [`CDB_NUM-1:0]            cdb_tag_i;
    rs_pkg::fu_mask_t                       fu_ready_i;
    logic [`IS_NUM-1:0]                     issue_valid_o;
    rs_pkg::tag_t [`IS_NUM-1:0]             issue_tag_o;
    rs_pkg::tag_t [`IS_NUM-1:0]             issue_src1_o;
    rs_pkg::tag_t [`IS_NUM-1:0]             issue_src2_o;
    rs_pkg::fu_mask_t [`IS_NUM-1:0]         issue_fu_o;

    // Reference model with one slot per destination tag
    logic [NTAG-1:0]                        m_pend;
    logic [NTAG-1:0]                        m_rdy1;
    logic [NTAG-1:0]                        m_rdy2;
    rs_pkg::tag_t                           m_src1 [0:NTAG-1];
    rs_pkg::tag_t                           m_src2 [0:NTAG-1];
    rs_pkg::fu_mask_t                       m_fu   [0:NTAG-1];
    int                                     npend;
    int                                     nready;
    int                                     exp_issue;
    rs_pkg::rs_cnt_t                        exp_avail;

    // Directed-check flags, driven like DUT inputs
    logic                                   chk_idle;
    logic                                   exp_vld;
    rs_pkg::tag_t                           exp_tag;

    // Staged inputs for the next edge
    rs_pkg::rs_cnt_t                        s_dp_num;
    rs_pkg::rs_inst_t [`DP_NUM-1:0]         s_inst;
    logic                                   s_flush;
    logic [`CDB_NUM-1:0]                    s_cdb_v;
    rs_pkg::tag_t [`CDB_NUM-1:0]            s_cdb_t;
    rs_pkg::fu_mask_t                       s_fu;
    logic                                   s_idle;
    logic                                   s_exp_vld;
    rs_pkg::tag_t                           s_exp_tag;

    rs_pkg::tag_t                           next_tag;
    rs_pkg::tag_t                           last_tag;
    logic [31:0]                            rng;
    int                                     errors = 0;
    int                                     ntests = 0;
    int                                     cycle_cnt = 0;

    rs_top uut (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .flush_i        (flush_i),
        .dp_num_i       (dp_num_i),
        .dp_inst_i      (dp_inst_i),
        .avail_num_o    (avail_num_o),
        .cdb_valid_i    (cdb_valid_i),
        .cdb_tag_i      (cdb_tag_i),
        .fu_ready_i     (fu_ready_i),
        .issue_valid_o  (issue_valid_o),
        .issue_tag_o    (issue_tag_o),
        .issue_src1_o   (issue_src1_o),
        .issue_src2_o   (issue_src2_o),
        .issue_fu_o     (issue_fu_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    //----------------------------------------------------------------
    // Reference model update at each edge
    //----------------------------------------------------------------
    always @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            m_pend <= '0;
        end else begin
            // Issued tags leave
            for (int k = 0; k < `IS_NUM; k++) begin
                if (issue_valid_o[k]) begin
                    m_pend[issue_tag_o[k]] <= 1'b0;
                end
            end
            // Wakeup of stored sources
            for (int t = 0; t < NTAG; t++) begin
                for (int c = 0; c < `CDB_NUM; c++) begin
                    if (m_pend[t] && cdb_valid_i[c] && cdb_tag_i[c] == m_src1[t]) begin
                        m_rdy1[t] <= 1'b1;
                    end
                    if (m_pend[t] && cdb_valid_i[c] && cdb_tag_i[c] == m_src2[t]) begin
                        m_rdy2[t] <= 1'b1;
                    end
                end
            end
            // New instructions override a same-cycle wakeup
            for (int k = 0; k < `DP_NUM; k++) begin
                if (rs_pkg::rs_cnt_t'(k) < dp_num_i) begin
                    m_pend[dp_inst_i[k].tag] <= 1'b1;
                    m_rdy1[dp_inst_i[k].tag] <= dp_inst_i[k].src1_ready;
                    m_rdy2[dp_inst_i[k].tag] <= dp_inst_i[k].src2_ready;
                    m_src1[dp_inst_i[k].tag] <= dp_inst_i[k].src1;
                    m_src2[dp_inst_i[k].tag] <= dp_inst_i[k].src2;
                    m_fu[dp_inst_i[k].tag]   <= dp_inst_i[k].fu;
                end
            end
        end
    end

    // Expected issue count and credit
    always_comb begin
        npend  = 0;
        nready = 0;
        for (int t = 0; t < NTAG; t++) begin
            if (m_pend[t]) begin
                npend++;
            end
            if (m_pend[t] && m_rdy1[t] && m_rdy2[t] && (|(m_fu[t] & fu_ready_i))) begin
                nready++;
            end
        end
        exp_issue = (nready < `IS_NUM) ? nready : `IS_NUM;
        exp_avail = rs_pkg::rs_cnt_t'((`RS_ENTRY_NUM - npend + exp_issue < `DP_NUM)
                     ? (`RS_ENTRY_NUM - npend + exp_issue) : `DP_NUM);
    end

    //----------------------------------------------------------------
    // Checks
    //----------------------------------------------------------------
    a_issue_count: assert property (@(posedge clk_i) disable iff (rst_i)
        $countones(issue_valid_o) == exp_issue)
        else begin
            $display("error at %0t: issue count differs from model", $time);
            errors = errors + 1;
        end

    a_avail: assert property (@(posedge clk_i) disable iff (rst_i)
        avail_num_o == exp_avail)
        else begin
            $display("error at %0t: avail_num_o differs from free entries", $time);
            errors = errors + 1;
        end

    a_credit: assert property (@(posedge clk_i) disable iff (rst_i)
        dp_num_i <= avail_num_o)
        else begin
            $display("error at %0t: dispatch exceeded the credit", $time);
            errors = errors + 1;
        end

    a_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        chk_idle |-> (avail_num_o == rs_pkg::rs_cnt_t'(`DP_NUM) && issue_valid_o == '0))
        else begin
            $display("error at %0t: station not empty after reset or flush", $time);
            errors = errors + 1;
        end

    a_expect: assert property (@(posedge clk_i) disable iff (rst_i)
        exp_vld |-> (issue_valid_o[0] && issue_tag_o[0] == exp_tag))
        else begin
            $display("error at %0t: expected tag %0d on channel 0", $time, exp_tag);
            errors = errors + 1;
        end

    // Same tag on two channels would be a double issue
    a_distinct: assert property (@(posedge clk_i) disable iff (rst_i)
        !(issue_valid_o[0] && issue_valid_o[1] && issue_tag_o[0] == issue_tag_o[1]))
        else begin
            $display("error at %0t: one tag issued on both channels", $time);
            errors = errors + 1;
        end

    for (genvar k = 0; k < `IS_NUM; k++) begin : g_chan
        a_pending_ready: assert property (@(posedge clk_i) disable iff (rst_i)
            issue_valid_o[k] |-> (m_pend[issue_tag_o[k]] && m_rdy1[issue_tag_o[k]]
                                  && m_rdy2[issue_tag_o[k]]))
            else begin
                $display("error at %0t: channel %0d issued a tag not pending and ready",
                         $time, k);
                errors = errors + 1;
            end
        a_unit_ready: assert property (@(posedge clk_i) disable iff (rst_i)
            issue_valid_o[k] |-> (|(m_fu[issue_tag_o[k]] & fu_ready_i)))
            else begin
                $display("error at %0t: channel %0d issued to a busy unit", $time, k);
                errors = errors + 1;
            end
        a_fields: assert property (@(posedge clk_i) disable iff (rst_i)
            issue_valid_o[k] |-> (issue_src1_o[k] == m_src1[issue_tag_o[k]]
                                  && issue_src2_o[k] == m_src2[issue_tag_o[k]]
                                  && issue_fu_o[k] == m_fu[issue_tag_o[k]]))
            else begin
                $display("error at %0t: channel %0d fields differ from dispatch", $time, k);
                errors = errors + 1;
            end
    end

    // Run limit
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    //----------------------------------------------------------------
    // Stimulus helpers
    //----------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Tag still stored, in flight, or already staged
    function automatic logic tag_busy(input rs_pkg::tag_t t);
        logic busy;
        busy = m_pend[t];
        for (int k = 0; k < `DP_NUM; k++) begin
            if (rs_pkg::rs_cnt_t'(k) < dp_num_i && dp_inst_i[k].tag == t) begin
                busy = 1'b1;
            end
            if (rs_pkg::rs_cnt_t'(k) < s_dp_num && s_inst[k].tag == t) begin
                busy = 1'b1;
            end
        end
        return busy;
    endfunction

    // Entries surely free at the next edge including this cycle's issue
    function automatic int room();
        int r;
        if (flush_i) begin
            r = `RS_ENTRY_NUM;
        end else begin
            r = `RS_ENTRY_NUM - npend + $countones(issue_valid_o) - int'(dp_num_i);
        end
        return r;
    endfunction

    task automatic stage_inst(input rs_pkg::tag_t src1, input rs_pkg::tag_t src2,
                              input logic r1, input logic r2, input rs_pkg::fu_mask_t fu);
        rs_pkg::rs_inst_t inst;
        while (tag_busy(next_tag)) begin
            next_tag = next_tag + rs_pkg::tag_t'(1);
        end
        inst.tag        = next_tag;
        inst.src1       = src1;
        inst.src2       = src2;
        inst.src1_ready = r1;
        inst.src2_ready = r2;
        inst.fu         = fu;
        for (int k = 0; k < `DP_NUM; k++) begin
            if (rs_pkg::rs_cnt_t'(k) == s_dp_num) begin
                s_inst[k] = inst;
            end
        end
        s_dp_num = s_dp_num + rs_pkg::rs_cnt_t'(1);
        last_tag = next_tag;
        next_tag = next_tag + rs_pkg::tag_t'(1);
    endtask

    // Apply the staged inputs at the edge, then settle to the falling edge
    task automatic tick();
        @(posedge clk_i);
        dp_num_i    <= s_dp_num;
        dp_inst_i   <= s_inst;
        flush_i     <= s_flush;
        cdb_valid_i <= s_cdb_v;
        cdb_tag_i   <= s_cdb_t;
        fu_ready_i  <= s_fu;
        chk_idle    <= s_idle;
        exp_vld     <= s_exp_vld;
        exp_tag     <= s_exp_tag;
        s_dp_num  = '0;
        s_flush   = 1'b0;
        s_cdb_v   = '0;
        s_idle    = 1'b0;
        s_exp_vld = 1'b0;
        @(negedge clk_i);
    endtask

    task automatic report(input string name, input int err_start);
        ntests++;
        $display("test %0d %s done with %0d errors", ntests, name, errors - err_start);
    endtask

    //----------------------------------------------------------------
    // Tests
    //----------------------------------------------------------------
    task automatic fill_blocked_then_drain();
        int n;
        s_fu = '0;
        while (room() > 0) begin
            n = (room() < `DP_NUM) ? room() : `DP_NUM;
            for (int k = 0; k < n; k++) begin
                rng = xorshift(rng);
                stage_inst(rs_pkg::tag_t'(rng[5:0]), rs_pkg::tag_t'(rng[11:6]), 1'b1, 1'b1,
                           rs_pkg::fu_mask_t'(1) << (int'(rng[19:12]) % `FU_NUM));
            end
            tick();
        end
        // Station full with avail_num_o held at zero
        repeat (3) tick();
        s_fu = '1;
        while (npend != 0) begin
            tick();
        end
    endtask

    task automatic random_stress();
        int n;
        for (int i = 0; i < STRESS_CYCLES; i++) begin
            rng  = xorshift(rng);
            s_fu = rng[4:0] | rng[9:5];
            n    = int'(rng[11:10]) % 3;
            if (n > room()) begin
                n = room();
            end
            for (int k = 0; k < n; k++) begin
                rng = xorshift(rng);
                stage_inst(rs_pkg::tag_t'(rng[2:0]), rs_pkg::tag_t'(rng[5:3]), rng[6], rng[7],
                           rs_pkg::fu_mask_t'(1) << (int'(rng[15:8]) % `FU_NUM));
            end
            rng        = xorshift(rng);
            s_cdb_v    = rng[1:0];
            s_cdb_t[0] = rs_pkg::tag_t'(rng[4:2]);
            s_cdb_t[1] = rs_pkg::tag_t'(rng[7:5]);
            s_flush    = (rng[15:8] == 8'd0);
            tick();
        end
    endtask

    initial begin
        int e0;
        rst_i       = 1'b1;
        flush_i     = 1'b0;
        dp_num_i    = '0;
        dp_inst_i   = '0;
        cdb_valid_i = '0;
        cdb_tag_i   = '0;
        fu_ready_i  = '0;
        chk_idle    = 1'b0;
        exp_vld     = 1'b0;
        exp_tag     = '0;
        s_dp_num    = '0;
        s_inst      = '0;
        s_flush     = 1'b0;
        s_cdb_v     = '0;
        s_cdb_t     = '0;
        s_fu        = '0;
        s_idle      = 1'b0;
        s_exp_vld   = 1'b0;
        s_exp_tag   = '0;
        next_tag    = '0;
        last_tag    = '0;
        rng         = 32'd13266;

        // First cycle after reset release must be empty
        e0 = errors;
        repeat (8) @(posedge clk_i);
        rst_i    <= 1'b0;
        chk_idle <= 1'b1;
        @(negedge clk_i);
        tick();
        report("reset", e0);

        // Ready instruction issues in the next cycle
        e0   = errors;
        s_fu = '1;
        stage_inst(6'd1, 6'd2, 1'b1, 1'b1, 5'b00001);
        tick();
        s_exp_vld = 1'b1;
        s_exp_tag = last_tag;
        tick();
        tick();
        report("ready_issue", e0);

        // Wakeup needs both broadcasts after dispatch
        // A broadcast of src1 in the dispatch cycle is ignored
        e0 = errors;
        stage_inst(6'd40, 6'd41, 1'b0, 1'b0, 5'b00010);
        s_cdb_v    = 2'b01;
        s_cdb_t[0] = 6'd40;
        tick();
        repeat (2) tick();
        // Only src2 wakes here so nothing may issue yet
        s_cdb_v    = 2'b10;
        s_cdb_t[1] = 6'd41;
        tick();
        repeat (2) tick();
        s_cdb_v    = 2'b01;
        s_cdb_t[0] = 6'd40;
        tick();
        s_exp_vld = 1'b1;
        s_exp_tag = last_tag;
        tick();
        tick();
        report("cdb_wakeup", e0);

        e0 = errors;
        fill_blocked_then_drain();
        report("backpressure_drain", e0);

        // Flush with blocked entries where issue in the flush cycle is allowed
        e0   = errors;
        s_fu = '0;
        stage_inst(6'd3, 6'd4, 1'b1, 1'b1, 5'b00100);
        stage_inst(6'd5, 6'd6, 1'b1, 1'b1, 5'b01000);
        tick();
        stage_inst(6'd7, 6'd8, 1'b1, 1'b1, 5'b10000);
        tick();
        tick();
        s_flush = 1'b1;
        s_fu    = '1;
        tick();
        s_idle = 1'b1;
        tick();
        repeat (3) tick();
        report("flush", e0);

        e0 = errors;
        random_stress();
        repeat (2) tick();
        report("random_stress", e0);

        $display("tests run %0d, errors %0d", ntests, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/rs_top.sv */
//--------------------------------------------------------------------
// Reservation station top level
// Storage array, dispatch allocator and issue select
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rs_params.svh"

module rs_top (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                flush_i,
    // Dispatch side
    input  rs_pkg::rs_cnt_t                     dp_num_i,
    input  rs_pkg::rs_inst_t [`DP_NUM-1:0]      dp_inst_i,
    output rs_pkg::rs_cnt_t                     avail_num_o,
    // Common data bus
    input  logic [`CDB_NUM-1:0]                 cdb_valid_i,
    input  rs_pkg::tag_t [`CDB_NUM-1:0]         cdb_tag_i,
    // Issue side
    input  rs_pkg::fu_mask_t                    fu_ready_i,
    output logic [`IS_NUM-1:0]                  issue_valid_o,
    output rs_pkg::tag_t [`IS_NUM-1:0]          issue_tag_o,
    output rs_pkg::tag_t [`IS_NUM-1:0]          issue_src1_o,
    output rs_pkg::tag_t [`IS_NUM-1:0]          issue_src2_o,
    output rs_pkg::fu_mask_t [`IS_NUM-1:0]      issue_fu_o
);

    // Per-entry state and selects shared by the three blocks
    rs_entry_if ent (
        .clk_i  (clk_i),
        .rst_i  (rst_i)
    );

    // Registered entries
    rs_entry_array u_array (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .flush_i        (flush_i),
        .cdb_valid_i    (cdb_valid_i),
        .cdb_tag_i      (cdb_tag_i),
        .ent            (ent.array)
    );

    // Entry allocation for incoming instructions
    rs_dispatch_alloc u_alloc (
        .dp_num_i       (dp_num_i),
        .dp_inst_i      (dp_inst_i),
        .avail_num_o    (avail_num_o),
        .ent            (ent.alloc)
    );

    // Oldest-index-first issue
    rs_issue_select u_issue (
        .fu_ready_i     (fu_ready_i),
        .issue_valid_o  (issue_valid_o),
        .issue_tag_o    (issue_tag_o),
        .issue_src1_o   (issue_src1_o),
        .issue_src2_o   (issue_src2_o),
        .issue_fu_o     (issue_fu_o),
        .ent            (ent.issue)
    );

endmodule

`default_nettype wire

/* rtl/rs_issue_select.sv */
//--------------------------------------------------------------------
// Issue selection
// Ready check, multi-output priority encoder and issue switch
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rs_params.svh"

module rs_issue_select (
    input  rs_pkg::fu_mask_t                    fu_ready_i,
    output logic [`IS_NUM-1:0]                  issue_valid_o,
    output rs_pkg::tag_t [`IS_NUM-1:0]          issue_tag_o,
    output rs_pkg::tag_t [`IS_NUM-1:0]          issue_src1_o,
    output rs_pkg::tag_t [`IS_NUM-1:0]          issue_src2_o,
    output rs_pkg::fu_mask_t [`IS_NUM-1:0]      issue_fu_o,
    rs_entry_if.issue                           ent
);

    // Entries that may leave this cycle
    rs_pkg::entry_vec_t                         issuable;

    // Priority encoder chain, one level per issue channel
    rs_pkg::entry_vec_t [`IS_NUM-1:0]           pe_bit;
    rs_pkg::rs_idx_t    [`IS_NUM-1:0]           pick_idx;
    logic               [`IS_NUM-1:0]           pick_vld;

    //----------------------------------------------------------------
    // Ready-to-issue check
    //----------------------------------------------------------------
    always_comb begin
        issuable = '0;
        for (int e = 0; e < `RS_ENTRY_NUM; e++) begin
            // Both sources ready and the unit class can take it
            issuable[e] = ent.entry_valid[e]
                        & ent.entry_inst[e].src1_ready
                        & ent.entry_inst[e].src2_ready
                        & (|(ent.entry_inst[e].fu & fu_ready_i));
        end
    end

    //----------------------------------------------------------------
    // Lowest-index issuable entries
    //----------------------------------------------------------------
    always_comb begin
        pe_bit   = '0;
        pick_idx = '0;
        pick_vld = '0;
        for (int k = 0; k < `IS_NUM; k++) begin
            // Mask out whatever the level above took
            if (k == 0) begin
                pe_bit[k] = issuable;
            end else if (pick_vld[k-1]) begin
                pe_bit[k] = pe_bit[k-1] & ~(rs_pkg::entry_vec_t'(1) << pick_idx[k-1]);
            end else begin
                pe_bit[k] = pe_bit[k-1];
            end
            for (int e = `RS_ENTRY_NUM - 1; e >= 0; e--) begin
                if (pe_bit[k][e]) begin
                    pick_idx[k] = rs_pkg::rs_idx_t'(e);
                    pick_vld[k] = 1'b1;
                end
            end
        end
    end

    //----------------------------------------------------------------
    // Issue switch
    //----------------------------------------------------------------
    always_comb begin
        ent.is_sel    = '0;
        issue_valid_o = '0;
        issue_tag_o   = '0;
        issue_src1_o  = '0;
        issue_src2_o  = '0;
        issue_fu_o    = '0;
        for (int k = 0; k < `IS_NUM; k++) begin
            if (pick_vld[k]) begin
                // Release the entry and report its tags
                ent.is_sel[pick_idx[k]] = 1'b1;
                issue_valid_o[k]        = 1'b1;
                issue_tag_o[k]          = ent.entry_inst[pick_idx[k]].tag;
                issue_src1_o[k]         = ent.entry_inst[pick_idx[k]].src1;
                issue_src2_o[k]         = ent.entry_inst[pick_idx[k]].src2;
                issue_fu_o[k]           = ent.entry_inst[pick_idx[k]].fu;
            end
        end
    end

    // One released entry per valid channel, so no entry goes out twice
    a_one_chan_per_entry: assert property (@(posedge ent.clk_i) disable iff (ent.rst_i)
        $countones(ent.is_sel) == $countones(issue_valid_o));

endmodule

`default_nettype wire

/* rtl/rs_dispatch_alloc.sv */
//--------------------------------------------------------------------
// Dispatch allocation
// Free-entry priority chain, dispatch switch and credit count
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rs_params.svh"

module rs_dispatch_alloc (
    input  rs_pkg::rs_cnt_t                     dp_num_i,
    input  rs_pkg::rs_inst_t [`DP_NUM-1:0]      dp_inst_i,
    output rs_pkg::rs_cnt_t                     avail_num_o,
    rs_entry_if.alloc                           ent
);

    // Empty now or released by issue this cycle
    rs_pkg::entry_vec_t                         free_vec;
    rs_pkg::rs_cnt_t                            free_cnt;

    // Priority encoder chain, one level per dispatch channel
    rs_pkg::entry_vec_t [`DP_NUM-1:0]           pe_bit;
    rs_pkg::rs_idx_t    [`DP_NUM-1:0]           pick_idx;
    logic               [`DP_NUM-1:0]           pick_vld;

    assign free_vec = ~ent.entry_valid | ent.is_sel;

    //----------------------------------------------------------------
    // Lowest-index free entries
    //----------------------------------------------------------------
    always_comb begin
        pe_bit   = '0;
        pick_idx = '0;
        pick_vld = '0;
        for (int k = 0; k < `DP_NUM; k++) begin
            // Each level sees the previous one minus its pick
            if (k == 0) begin
                pe_bit[k] = free_vec;
            end else if (pick_vld[k-1]) begin
                pe_bit[k] = pe_bit[k-1] & ~(rs_pkg::entry_vec_t'(1) << pick_idx[k-1]);
            end else begin
                pe_bit[k] = pe_bit[k-1];
            end
            // Scan downward so the lowest set bit is kept
            for (int e = `RS_ENTRY_NUM - 1; e >= 0; e--) begin
                if (pe_bit[k][e]) begin
                    pick_idx[k] = rs_pkg::rs_idx_t'(e);
                    pick_vld[k] = 1'b1;
                end
            end
        end
    end

    //----------------------------------------------------------------
    // Dispatch switch
    //----------------------------------------------------------------
    always_comb begin
        ent.dp_sel  = '0;
        ent.dp_inst = '0;
        for (int k = 0; k < `DP_NUM; k++) begin
            // Only channels below dp_num_i carry an instruction
            if (pick_vld[k] && (rs_pkg::rs_cnt_t'(k) < dp_num_i)) begin
                ent.dp_sel[pick_idx[k]]  = 1'b1;
                ent.dp_inst[pick_idx[k]] = dp_inst_i[k];
            end
        end
    end

    //----------------------------------------------------------------
    // Credit toward the dispatcher
    //----------------------------------------------------------------
    always_comb begin
        free_cnt = '0;
        for (int e = 0; e < `RS_ENTRY_NUM; e++) begin
            free_cnt = free_cnt + rs_pkg::rs_cnt_t'(free_vec[e]);
        end
    end

    // Saturate at the dispatch width
    assign avail_num_o = (free_cnt >= rs_pkg::rs_cnt_t'(`DP_NUM)) ?
                         rs_pkg::rs_cnt_t'(`DP_NUM) : free_cnt;

    // Dispatcher must respect the credit it was given
    a_no_over_dispatch: assert property (@(posedge ent.clk_i) disable iff (ent.rst_i)
        dp_num_i <= avail_num_o);

endmodule

`default_nettype wire

/* rtl/rs_entry_array.sv */
//--------------------------------------------------------------------
// Reservation station entry storage
// Dispatch write, issue release, CDB wakeup and flush
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rs_params.svh"

module rs_entry_array (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                flush_i,
    input  logic [`CDB_NUM-1:0]                 cdb_valid_i,
    input  rs_pkg::tag_t [`CDB_NUM-1:0]         cdb_tag_i,
    rs_entry_if.array                           ent
);

    // Entry state
    rs_pkg::entry_vec_t                         valid_q;
    rs_pkg::rs_inst_t [`RS_ENTRY_NUM-1:0]       inst_q;

    // Per-entry CDB match on each source
    rs_pkg::entry_vec_t                         src1_hit;
    rs_pkg::entry_vec_t                         src2_hit;

    //----------------------------------------------------------------
    // CDB comparator network
    //----------------------------------------------------------------
    always_comb begin
        src1_hit = '0;
        src2_hit = '0;
        for (int e = 0; e < `RS_ENTRY_NUM; e++) begin
            for (int c = 0; c < `CDB_NUM; c++) begin
                // Only live entries listen to the bus
                if (valid_q[e] && cdb_valid_i[c]) begin
                    if (cdb_tag_i[c] == inst_q[e].src1) begin
                        src1_hit[e] = 1'b1;
                    end
                    if (cdb_tag_i[c] == inst_q[e].src2) begin
                        src2_hit[e] = 1'b1;
                    end
                end
            end
        end
    end

    //----------------------------------------------------------------
    // Valid bits
    //----------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            // Squash everything
            valid_q <= '0;
        end else begin
            for (int e = 0; e < `RS_ENTRY_NUM; e++) begin
                // Dispatch wins over issue on a reused entry
                if (ent.dp_sel[e]) begin
                    valid_q[e] <= 1'b1;
                end else if (ent.is_sel[e]) begin
                    valid_q[e] <= 1'b0;
                end
            end
        end
    end

    //----------------------------------------------------------------
    // Payload and ready bits
    //----------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        for (int e = 0; e < `RS_ENTRY_NUM; e++) begin
            if (ent.dp_sel[e]) begin
                // New instruction ignores a same-cycle broadcast
                inst_q[e] <= ent.dp_inst[e];
            end else begin
                // Each source wakes on its own
                if (src1_hit[e]) begin
                    inst_q[e].src1_ready <= 1'b1;
                end
                if (src2_hit[e]) begin
                    inst_q[e].src2_ready <= 1'b1;
                end
            end
        end
    end

    assign ent.entry_valid = valid_q;
    assign ent.entry_inst  = inst_q;

    // Allocator must only target entries that are empty or leaving now
    a_dp_free_entry: assert property (@(posedge clk_i) disable iff (rst_i)
        (ent.dp_sel & valid_q & ~ent.is_sel) == '0);

endmodule

`default_nettype wire

/* rtl/rs_entry_if.sv */
//--------------------------------------------------------------------
// Per-entry state and per-entry select bundle, with modports
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rs_params.svh"

interface rs_entry_if (
    input  logic clk_i,
    input  logic rst_i
);

    // Entry state from the storage array
    rs_pkg::entry_vec_t                         entry_valid;
    rs_pkg::rs_inst_t [`RS_ENTRY_NUM-1:0]       entry_inst;

    // Write selects and routed payload from the allocator
    rs_pkg::entry_vec_t                         dp_sel;
    rs_pkg::rs_inst_t [`RS_ENTRY_NUM-1:0]       dp_inst;

    // Entries leaving this cycle, from issue select
    rs_pkg::entry_vec_t                         is_sel;

    modport array (output entry_valid, entry_inst,
                   input  dp_sel, dp_inst, is_sel);

    // Clock and reset reach the combinational blocks for their checks only
    modport alloc (input  clk_i, rst_i, entry_valid, is_sel,
                   output dp_sel, dp_inst);

    modport issue (input  clk_i, rst_i, entry_valid, entry_inst,
                   output is_sel);

endinterface

`default_nettype wire

/* rtl/rs_pkg.sv */
//--------------------------------------------------------------------
// Shared types for the reservation station
// Vector typedefs and the stored instruction record
//--------------------------------------------------------------------
`default_nettype none

`include "rs_params.svh"

package rs_pkg;

    // Physical register tag
    typedef logic [`TAG_WIDTH-1:0]      tag_t;

    // Entry index and entry count (0..RS_ENTRY_NUM)
    typedef logic [`RS_IDX_WIDTH-1:0]   rs_idx_t;
    typedef logic [`RS_CNT_WIDTH-1:0]   rs_cnt_t;

    // One-hot unit class
    typedef logic [`FU_NUM-1:0]         fu_mask_t;

    // One bit per entry
    typedef logic [`RS_ENTRY_NUM-1:0]   entry_vec_t;

    //----------------------------------------------------------------
    // Stored instruction
    //----------------------------------------------------------------
    // Only the fields that matter for wakeup and select are kept
    typedef struct packed {
        tag_t       tag;
        tag_t       src1;
        tag_t       src2;
        logic       src1_ready;
        logic       src2_ready;
        fu_mask_t   fu;
    } rs_inst_t;

endpackage

`default_nettype wire

/* rtl/rs_params.svh */
//--------------------------------------------------------------------
// Reservation station sizing constants
// Entry count, channel counts and field widths
//--------------------------------------------------------------------
`ifndef RS_PARAMS_SVH
`define RS_PARAMS_SVH

// Storage depth
`define RS_ENTRY_NUM    8
// Dispatch, issue and CDB channels per cycle
`define DP_NUM          2
`define IS_NUM          2
`define CDB_NUM         2

// Physical register tag width
`define TAG_WIDTH       6
// Unit class bits ALU 0, MULT 1, LOAD 2, STORE 3, BR 4
`define FU_NUM          5

// Derived widths for entry index and entry count
`define RS_IDX_WIDTH    $clog2(`RS_ENTRY_NUM)
`define RS_CNT_WIDTH    $clog2(`RS_ENTRY_NUM + 1)

`endif
